/* verilog/pipe_trace_pkg.sv */
// Pipeline trace shared types
package pipe_trace_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int ENTRY_W   = 64;
  localparam int ID_INFO_W = 40;
  localparam int ST_ADDR_W = 40;
  localparam int SLOTS     = 3;

  // Debugger selector values
  typedef enum logic [1:0] {
    SEL_NONE = 2'd0,
    SEL_IDU  = 2'd1,
    SEL_RTU  = 2'd2,
    SEL_LSU  = 2'd3
  } pipe_sel_e;

  // Decode record sitting in the low bits of an entry
  typedef struct packed {
    logic [ENTRY_W-ID_INFO_W-1:0] pad;
    logic [ID_INFO_W-1:0]         rec;
  } id_view_t;

  // One trace entry, seen whole or as a decode record
  typedef union packed {
    logic [ENTRY_W-1:0] word;
    id_view_t           id;
  } trace_entry_u;

  // ========================================
  // Stage ports
  // ========================================
  typedef struct packed {
    logic [SLOTS-1:0]                vld;
    logic [SLOTS-1:0][ID_INFO_W-1:0] info;
  } idu_trace_t;

  typedef struct packed {
    logic [SLOTS-1:0]              vld;
    logic [SLOTS-1:0][ENTRY_W-1:0] info;
  } rtu_trace_t;

  typedef struct packed {
    logic                 req;
    logic [ST_ADDR_W-1:0] addr;
    logic [ENTRY_W-1:0]   data;
  } lsu_store_t;

  // Write request, slot 0 is the oldest entry
  typedef struct packed {
    logic [SLOTS-1:0]               wen;
    trace_entry_u [SLOTS-1:0]       entry;
  } trace_wr_t;

  // Trace enables back to the stages
  typedef struct packed {
    logic id_inst_en;
    logic retire_info_en;
    logic lsu_info_en;
  } stage_en_t;

endpackage

/* verilog/trace_src_sel.sv */
// Trace source selection
module trace_src_sel
  import pipe_trace_pkg::*;
(
  input  logic             cpuclk,
  input  logic             cpurst_b,
  input  logic             update_dr_en,
  input  logic             pipesel_reg_sel,
  input  logic [63:0]      wdata,
  input  logic             pipefifo_wen,
  input  idu_trace_t       idu,
  input  rtu_trace_t       rtu,
  input  lsu_store_t       lsu,
  output trace_wr_t        wr,
  output stage_en_t        stage_en,
  output logic [31:0]      pipesel_regs_data
);

  pipe_sel_e        pipesel;
  logic [SLOTS-1:0] src_vld;

  // ========================================
  // Selector register
  // ========================================
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pipesel <= SEL_NONE;
    end
    else if (update_dr_en && pipesel_reg_sel)
    begin
      pipesel <= pipe_sel_e'(wdata[1:0]);
    end
  end

  assign pipesel_regs_data = {30'b0, pipesel};

  // Only the chosen stage sees its enable
  assign stage_en.id_inst_en     = (pipesel == SEL_IDU) && pipefifo_wen;
  assign stage_en.retire_info_en = (pipesel == SEL_RTU) && pipefifo_wen;
  assign stage_en.lsu_info_en    = (pipesel == SEL_LSU) && pipefifo_wen;

  // ========================================
  // Source steering
  // ========================================
  always_comb
  begin
    src_vld  = '0;
    wr.entry = '0;
    case (pipesel)
      SEL_IDU:
      begin
        src_vld = idu.vld;
        for (int k = 0; k < SLOTS; k++)
        begin
          wr.entry[k].id.pad = '0;
          wr.entry[k].id.rec = idu.info[k];
        end
      end
      SEL_RTU:
      begin
        src_vld = rtu.vld;
        for (int k = 0; k < SLOTS; k++)
        begin
          wr.entry[k].word = rtu.info[k];
        end
      end
      SEL_LSU:
      begin
        // Store data first, then its address
        src_vld          = {1'b0, {2{lsu.req}}};
        wr.entry[0].word = lsu.data;
        wr.entry[1].word = {{(ENTRY_W-ST_ADDR_W){1'b0}}, lsu.addr};
      end
      default:
      begin
        src_vld = '0;
      end
    endcase
  end

  assign wr.wen = src_vld & {SLOTS{pipefifo_wen}};

endmodule

/* verilog/trace_fifo_ptr.sv */
// Trace buffer pointer control
module trace_fifo_ptr
  import pipe_trace_pkg::*;
#(
  parameter int TRACE_DEPTH = 16
)
(
  input  logic                                     cpuclk,
  input  logic                                     cpurst_b,
  input  logic [SLOTS-1:0]                         wr_en,
  input  logic                                     pipefifo_ren,
  output logic [SLOTS-1:0][$clog2(TRACE_DEPTH)-1:0] wr_idx,
  output logic [$clog2(TRACE_DEPTH)-1:0]           rd_idx
);

  localparam int IDX_W = $clog2(TRACE_DEPTH);
  localparam int PTR_W = IDX_W + 1;

  logic [PTR_W-1:0]            wptr;
  logic [PTR_W-1:0]            rptr;
  logic [SLOTS-1:0][PTR_W-1:0] wptr_k;
  logic [PTR_W-1:0]            wptr_inc;
  logic [PTR_W-1:0]            rptr_inc;
  logic                        create_vld;
  logic                        create_one;
  logic                        create_two;
  logic                        create_thr;
  logic                        fifo_full;
  logic                        one_entry_left;
  logic                        two_entry_left;

  // ========================================
  // Slot addresses
  // ========================================
  always_comb
  begin
    for (int k = 0; k < SLOTS; k++)
    begin
      wptr_k[k] = wptr + PTR_W'(k);
      wr_idx[k] = wptr_k[k][IDX_W-1:0];
    end
  end

  assign rd_idx = rptr[IDX_W-1:0];

  // Valid patterns are 001, 011 or 111
  assign create_vld = |wr_en;
  assign create_one = (wr_en == 3'b001);
  assign create_two = (wr_en == 3'b011);
  assign create_thr = (wr_en == 3'b111);

  // ========================================
  // Space detection
  // ========================================
  // Same index with opposite wrap bit means the pointers are a depth apart
  assign fifo_full = (wptr_k[0][IDX_W-1:0] == rptr[IDX_W-1:0]) &&
                     (wptr_k[0][IDX_W] ^ rptr[IDX_W]);

  assign one_entry_left = (wptr_k[1][IDX_W-1:0] == rptr[IDX_W-1:0]) &&
                          (wptr_k[1][IDX_W] ^ rptr[IDX_W]);

  assign two_entry_left = (wptr_k[2][IDX_W-1:0] == rptr[IDX_W-1:0]) &&
                          (wptr_k[2][IDX_W] ^ rptr[IDX_W]);

  // ========================================
  // Pointer increments
  // ========================================
  always_comb
  begin
    if (create_thr)
      wptr_inc = PTR_W'(3);
    else if (create_two)
      wptr_inc = PTR_W'(2);
    else if (create_one)
      wptr_inc = PTR_W'(1);
    else
      wptr_inc = '0;
  end

  // Overflow pushes the oldest entries out
  always_comb
  begin
    rptr_inc = '0;
    if (create_vld)
    begin
      if (create_thr && fifo_full)
        rptr_inc = PTR_W'(3);
      else if ((create_thr && one_entry_left) || (create_two && fifo_full))
        rptr_inc = PTR_W'(2);
      else if ((create_thr && two_entry_left) || (create_two && one_entry_left) ||
               (create_one && fifo_full))
        rptr_inc = PTR_W'(1);
    end
    else if (pipefifo_ren)
    begin
      rptr_inc = PTR_W'(1);
    end
  end

  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else
    begin
      if (create_vld)
        wptr <= wptr + wptr_inc;
      if (create_vld || pipefifo_ren)
        rptr <= rptr + rptr_inc;
    end
  end

endmodule

/* verilog/trace_fifo_mem.sv */
// Trace buffer storage
module trace_fifo_mem
  import pipe_trace_pkg::*;
#(
  parameter int TRACE_DEPTH = 16
)
(
  input  logic                                     cpuclk,
  input  logic                                     cpurst_b,
  input  trace_wr_t                                wr,
  input  logic [SLOTS-1:0][$clog2(TRACE_DEPTH)-1:0] wr_idx,
  input  logic [$clog2(TRACE_DEPTH)-1:0]           rd_idx,
  input  logic                                     pipefifo_ren,
  output trace_entry_u                             pipefifo_regs_data
);

  localparam int IDX_W = $clog2(TRACE_DEPTH);

  trace_entry_u mem [TRACE_DEPTH];

  // ========================================
  // Entry write
  // ========================================
  for (genvar i = 0; i < TRACE_DEPTH; i++)
  begin : g_entry
    logic         hit;
    trace_entry_u din;

    // Scan high to low so the lowest slot wins
    always_comb
    begin
      hit = 1'b0;
      din = '0;
      for (int k = SLOTS - 1; k >= 0; k--)
      begin
        if (wr.wen[k] && (wr_idx[k] == IDX_W'(i)))
        begin
          hit = 1'b1;
          din = wr.entry[k];
        end
      end
    end

    always_ff @(posedge cpuclk or negedge cpurst_b)
    begin
      if (!cpurst_b)
      begin
        mem[i] <= '0;
      end
      else if (hit)
      begin
        mem[i] <= din;
      end
    end
  end

  // ========================================
  // Read port
  // ========================================
  // Held until the next read strobe
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pipefifo_regs_data <= '0;
    end
    else if (pipefifo_ren)
    begin
      pipefifo_regs_data <= mem[rd_idx];
    end
  end

endmodule

/* verilog/pipe_trace.sv */
// Pipeline trace buffer top
module pipe_trace
  import pipe_trace_pkg::*;
#(
  parameter int TRACE_DEPTH = 16
)
(
  input  logic         cpuclk,
  input  logic         cpurst_b,
  input  logic         update_dr_en,
  input  logic         pipesel_reg_sel,
  input  logic [63:0]  wdata,
  input  logic         pipefifo_wen,
  input  logic         pipefifo_ren,
  input  idu_trace_t   idu,
  input  rtu_trace_t   rtu,
  input  lsu_store_t   lsu,
  output stage_en_t    stage_en,
  output logic [31:0]  pipesel_regs_data,
  output trace_entry_u pipefifo_regs_data
);

  localparam int IDX_W = $clog2(TRACE_DEPTH);

  trace_wr_t                   wr;
  logic [SLOTS-1:0][IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0]            rd_idx;

  // ========================================
  // Source selection
  // ========================================
  trace_src_sel u_src_sel (
    .cpuclk            (cpuclk),
    .cpurst_b          (cpurst_b),
    .update_dr_en      (update_dr_en),
    .pipesel_reg_sel   (pipesel_reg_sel),
    .wdata             (wdata),
    .pipefifo_wen      (pipefifo_wen),
    .idu               (idu),
    .rtu               (rtu),
    .lsu               (lsu),
    .wr                (wr),
    .stage_en          (stage_en),
    .pipesel_regs_data (pipesel_regs_data)
  );

  // ========================================
  // Circular buffer
  // ========================================
  trace_fifo_ptr #(
    .TRACE_DEPTH (TRACE_DEPTH)
  ) u_fifo_ptr (
    .cpuclk       (cpuclk),
    .cpurst_b     (cpurst_b),
    .wr_en        (wr.wen),
    .pipefifo_ren (pipefifo_ren),
    .wr_idx       (wr_idx),
    .rd_idx       (rd_idx)
  );

  trace_fifo_mem #(
    .TRACE_DEPTH (TRACE_DEPTH)
  ) u_fifo_mem (
    .cpuclk             (cpuclk),
    .cpurst_b           (cpurst_b),
    .wr                 (wr),
    .wr_idx             (wr_idx),
    .rd_idx             (rd_idx),
    .pipefifo_ren       (pipefifo_ren),
    .pipefifo_regs_data (pipefifo_regs_data)
  );

endmodule

/* verification/pipe_trace_sva.sv */
// Trace buffer strobe checks
module pipe_trace_sva
  import pipe_trace_pkg::*;
#(
  parameter int TRACE_DEPTH = 16
)
(
  input logic                           cpuclk,
  input logic                           cpurst_b,
  input logic [SLOTS-1:0]               wr_en,
  input logic                           pipefifo_ren,
  input logic [$clog2(TRACE_DEPTH):0]   wptr,
  input logic [$clog2(TRACE_DEPTH):0]   rptr
);

  localparam int PTR_W = $clog2(TRACE_DEPTH) + 1;

  logic [PTR_W-1:0] used;

  // Assertion failures so far
  int fail_cnt = 0;

  // Wrap-aware occupancy
  assign used = wptr - rptr;

  a_no_rw_overlap: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    !((|wr_en) && pipefifo_ren))
  else
  begin
    fail_cnt++;
    $error("read and write strobes high in the same cycle");
  end

  a_wen_contiguous: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    wr_en inside {3'b000, 3'b001, 3'b011, 3'b111})
  else
  begin
    fail_cnt++;
    $error("write enables not contiguous from slot 0");
  end

  a_ptr_span: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    ((|wr_en) || pipefifo_ren) |=> (used <= TRACE_DEPTH))
  else
  begin
    fail_cnt++;
    $error("write pointer ahead of read pointer by more than the depth");
  end

endmodule

bind trace_fifo_ptr pipe_trace_sva #(.TRACE_DEPTH(TRACE_DEPTH)) u_sva (
  .cpuclk       (cpuclk),
  .cpurst_b     (cpurst_b),
  .wr_en        (wr_en),
  .pipefifo_ren (pipefifo_ren),
  .wptr         (wptr),
  .rptr         (rptr)
);

/* verification/tb_pipe_trace.sv */
// Pipeline trace buffer testbench
module tb_pipe_trace
  import pipe_trace_pkg::*;
();

  localparam int DEPTH = 16;

  logic         cpuclk;
  logic         cpurst_b;
  logic         update_dr_en;
  logic         pipesel_reg_sel;
  logic [63:0]  wdata;
  logic         pipefifo_wen;
  logic         pipefifo_ren;
  idu_trace_t   idu;
  rtu_trace_t   rtu;
  lsu_store_t   lsu;
  stage_en_t    stage_en;
  logic [31:0]  pipesel_regs_data;
  trace_entry_u pipefifo_regs_data;

  integer       seed;
  string        test_name;
  pipe_sel_e    cur_sel;
  trace_entry_u ref_q[$];
  int           issued;
  int           checked;
  pipe_sel_e    sel_list[4] = '{SEL_IDU, SEL_RTU, SEL_LSU, SEL_NONE};

  pipe_trace #(.TRACE_DEPTH(DEPTH)) dut_i (
    .cpuclk             (cpuclk),
    .cpurst_b           (cpurst_b),
    .update_dr_en       (update_dr_en),
    .pipesel_reg_sel    (pipesel_reg_sel),
    .wdata              (wdata),
    .pipefifo_wen       (pipefifo_wen),
    .pipefifo_ren       (pipefifo_ren),
    .idu                (idu),
    .rtu                (rtu),
    .lsu                (lsu),
    .stage_en           (stage_en),
    .pipesel_regs_data  (pipesel_regs_data),
    .pipefifo_regs_data (pipefifo_regs_data)
  );

  always #50 cpuclk = ~cpuclk;

  // ========================================
  // Reference model
  // ========================================
  // Keeps only the newest DEPTH entries
  function automatic void ref_push(input trace_entry_u e);
    ref_q.push_back(e);
    if (ref_q.size() > DEPTH)
      void'(ref_q.pop_front());
  endfunction

  function automatic trace_entry_u ref_pop();
    return ref_q.pop_front();
  endfunction

  function automatic stage_en_t ref_stage_en(input pipe_sel_e sel, input logic wen);
    stage_en_t e;
    e = '0;
    e.id_inst_en     = wen && (sel == SEL_IDU);
    e.retire_info_en = wen && (sel == SEL_RTU);
    e.lsu_info_en    = wen && (sel == SEL_LSU);
    return e;
  endfunction

  // ========================================
  // Compare tasks
  // ========================================
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_entry(input string name, input trace_entry_u exp, input trace_entry_u act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp.word, act.word));
  endtask

  task automatic check_sel(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_en(input string name, input stage_en_t exp, input stage_en_t act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
  endtask

  // Read data lands on the strobe edge, checked half a cycle later
  always @(posedge cpuclk)
  begin : read_checker
    trace_entry_u exp_rd;
    if (cpurst_b && pipefifo_ren)
    begin
      if (ref_q.size() == 0)
      begin
        fail_run("read strobe issued with no expected entry left");
      end
      else
      begin
        exp_rd = ref_pop();
        @(negedge cpuclk);
        check_entry(test_name, exp_rd, pipefifo_regs_data);
        checked++;
      end
    end
  end

  // ========================================
  // Stimulus tasks
  // ========================================
  task automatic step();
    @(posedge cpuclk);
    #10;
  endtask

  task automatic set_sel(input pipe_sel_e sel);
    step();
    wdata           = {$random(seed), $random(seed)};
    wdata[1:0]      = sel;
    update_dr_en    = 1'b1;
    pipesel_reg_sel = 1'b1;
    step();
    update_dr_en    = 1'b0;
    pipesel_reg_sel = 1'b0;
    cur_sel         = sel;
    check_sel({test_name, "_readback"}, 32'(sel), pipesel_regs_data);
  endtask

  // No valids are raised, so the strobe adds nothing
  task automatic check_stage_en();
    pipefifo_wen = 1'b0;
    #20;
    check_en({test_name, "_en_idle"}, ref_stage_en(cur_sel, 1'b0), stage_en);
    step();
    pipefifo_wen = 1'b1;
    #20;
    check_en({test_name, "_en_wen"}, ref_stage_en(cur_sel, 1'b1), stage_en);
    step();
    pipefifo_wen = 1'b0;
  endtask

  task automatic write_cycle(input logic [SLOTS-1:0] vld, input logic st_req);
    logic [63:0]  r;
    trace_entry_u e;
    step();
    for (int k = 0; k < SLOTS; k++)
    begin
      r = {$random(seed), $random(seed)};
      idu.info[k] = r[ID_INFO_W-1:0];
      rtu.info[k] = {$random(seed), $random(seed)};
    end
    r            = {$random(seed), $random(seed)};
    idu.vld      = vld;
    rtu.vld      = vld;
    lsu.req      = st_req;
    lsu.addr     = r[ST_ADDR_W-1:0];
    lsu.data     = {$random(seed), $random(seed)};
    pipefifo_wen = 1'b1;
    for (int k = 0; k < SLOTS; k++)
    begin
      if (vld[k] && cur_sel == SEL_IDU)
      begin
        e.word = 64'(idu.info[k]);
        ref_push(e);
      end
      if (vld[k] && cur_sel == SEL_RTU)
      begin
        e.word = rtu.info[k];
        ref_push(e);
      end
    end
    if (st_req && cur_sel == SEL_LSU)
    begin
      e.word = lsu.data;
      ref_push(e);
      e.word = 64'(lsu.addr);
      ref_push(e);
    end
  endtask

  task automatic end_writes();
    step();
    pipefifo_wen = 1'b0;
    idu.vld      = '0;
    rtu.vld      = '0;
    lsu.req      = 1'b0;
  endtask

  task automatic read_entries(input int n);
    int cycles;
    step();
    pipefifo_ren = 1'b1;
    issued += n;
    repeat (n) step();
    pipefifo_ren = 1'b0;
    cycles = 0;
    while (checked != issued)
    begin
      @(posedge cpuclk);
      cycles++;
      if (cycles > 200)
        fail_run("timed out waiting for the read checker to finish");
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial
  begin
    seed            = 32'h96de_819d;
    cpuclk          = 1'b0;
    cpurst_b        = 1'b0;
    update_dr_en    = 1'b0;
    pipesel_reg_sel = 1'b0;
    wdata           = '0;
    pipefifo_wen    = 1'b0;
    pipefifo_ren    = 1'b0;
    idu             = '0;
    rtu             = '0;
    lsu             = '0;
    cur_sel         = SEL_NONE;
    issued          = 0;
    checked         = 0;
    repeat (8) @(posedge cpuclk);
    #10;
    cpurst_b = 1'b1;

    // Selector comes out of reset as SEL_NONE, so the strobe enables nothing
    test_name = "reset";
    check_sel("reset_readback", 32'h0, pipesel_regs_data);
    check_stage_en();

    test_name = "selector";
    foreach (sel_list[i])
    begin
      set_sel(sel_list[i]);
      check_stage_en();
    end

    test_name = "decode";
    set_sel(SEL_IDU);
    repeat (4) write_cycle(3'b111, 1'b0);
    end_writes();
    read_entries(12);

    test_name = "retire";
    set_sel(SEL_RTU);
    write_cycle(3'b001, 1'b0);
    write_cycle(3'b011, 1'b0);
    write_cycle(3'b111, 1'b0);
    write_cycle(3'b011, 1'b0);
    write_cycle(3'b001, 1'b0);
    end_writes();
    read_entries(9);

    // A stray entry from SEL_NONE would shift the last store out of place
    test_name = "store";
    set_sel(SEL_LSU);
    write_cycle(3'b000, 1'b1);
    write_cycle(3'b000, 1'b1);
    write_cycle(3'b000, 1'b0);
    end_writes();
    set_sel(SEL_NONE);
    write_cycle(3'b111, 1'b1);
    end_writes();
    set_sel(SEL_LSU);
    write_cycle(3'b000, 1'b1);
    end_writes();
    read_entries(6);

    test_name = "overflow";
    set_sel(SEL_RTU);
    repeat (7) write_cycle(3'b111, 1'b0);
    end_writes();
    read_entries(DEPTH);

    if (dut_i.u_fifo_ptr.u_sva.fail_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* pipe_trace.f */
verilog/pipe_trace_pkg.sv
verilog/trace_src_sel.sv
verilog/trace_fifo_ptr.sv
verilog/trace_fifo_mem.sv
verilog/pipe_trace.sv
verification/pipe_trace_sva.sv
verification/tb_pipe_trace.sv
